// File: rtl/valu_defs.svh
`ifndef VALU_DEFS_SVH
`define VALU_DEFS_SVH

// vector register width in bits
`define VALU_VLEN 128

// population count works on two halves
`define VALU_HALF 64

// reorder buffer entry tag
`define VALU_TAG_W 3

// reservation station entries
`define VALU_RS_DEPTH 4

`endif

// File: rtl/valu_pkg.sv
`default_nettype none

`include "valu_defs.svh"

package valu_pkg;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_SADDU,
    OP_MINU,
    OP_MAXU,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_CPOP
  } alu_op_e;

  // ignored by the mask group and cpop
  typedef enum logic [1:0] {
    EEW8,
    EEW16,
    EEW32
  } eew_e;

  typedef struct packed {
    logic [`VALU_TAG_W-1:0]      rob_tag;
    alu_op_e                     opcode;
    eew_e                        eew;
    logic [`VALU_VLEN-1:0]       vs1;
    logic [`VALU_VLEN-1:0]       vs2;
  } alu_uop_t;

  typedef struct packed {
    logic [`VALU_TAG_W-1:0]      rob_tag;
    logic [`VALU_VLEN-1:0]       w_data;
    logic                        vsaturate;
  } pu2rob_t;

  // second stage contents
  typedef struct packed {
    logic [`VALU_TAG_W-1:0]      rob_tag;
    alu_op_e                     opcode;
    logic [`VALU_VLEN-1:0]       result_data;
    logic [$clog2(`VALU_HALF):0] cnt_lo;
    logic [$clog2(`VALU_HALF):0] cnt_hi;
    logic                        vsaturate;
  } pipe_data_t;

endpackage

`default_nettype wire

// File: rtl/valu_rs.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_defs.svh"

module valu_rs
(
  clk,
  arst_n,
  push,
  push_uop,
  full,
  trap_flush,
  pop_rs,
  uop_valid,
  uop
);
  input  logic                clk;
  input  logic                arst_n;
  input  logic                push;
  input  valu_pkg::alu_uop_t  push_uop;
  output logic                full;
  input  logic                trap_flush;
  input  logic                pop_rs;
  output logic                uop_valid;
  output valu_pkg::alu_uop_t  uop;

  localparam int DEPTH = `VALU_RS_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  valu_pkg::alu_uop_t   mem [DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [PTR_W:0]       count;
  logic                 wr_en;
  logic                 rd_en;

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full      = (count == (PTR_W + 1)'(DEPTH));
  assign uop_valid = (count != '0);
  assign uop       = mem[rd_ptr];

  // push while full is dropped
  assign wr_en = push & ~full;
  assign rd_en = pop_rs & uop_valid;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_uop;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (trap_flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/valu_arith.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_defs.svh"

module valu_arith
(
  uop_valid,
  uop,
  result_valid,
  result
);
  input  logic                uop_valid;
  input  valu_pkg::alu_uop_t  uop;
  output logic                result_valid;
  output valu_pkg::pu2rob_t   result;

  localparam int NBYTE = `VALU_VLEN / 8;

  logic [`VALU_VLEN-1:0]  data;
  logic                   sat;

  // a and b already masked to the element width
  function automatic logic [32:0] elem_op(valu_pkg::alu_op_e op, logic [31:0] a,
                                          logic [31:0] b, logic [31:0] wmask);
    logic [32:0] sum;
    logic [31:0] r;
    logic        clip;
    sum  = {1'b0, a} + {1'b0, b};
    clip = 1'b0;
    case (op)
      valu_pkg::OP_ADD:   r = sum[31:0];
      valu_pkg::OP_SUB:   r = a - b;
      valu_pkg::OP_SADDU: begin
        clip = (sum > {1'b0, wmask});
        r    = clip ? wmask : sum[31:0];
      end
      valu_pkg::OP_MINU:  r = (a < b) ? a : b;
      valu_pkg::OP_MAXU:  r = (a < b) ? b : a;
      default:            r = '0;
    endcase
    return {clip, r & wmask};
  endfunction

  always_comb begin
    logic [1:0]  lane_m;
    logic [31:0] wmask;
    logic [32:0] r;
    data = '0;
    sat  = 1'b0;
    case (uop.eew)
      valu_pkg::EEW8:  lane_m = 2'd0;
      valu_pkg::EEW16: lane_m = 2'd1;
      default:         lane_m = 2'd3;
    endcase
    wmask = 32'hffff_ffff >> (8 * (3 - lane_m));
    // walk bytes, act on the first byte of each element
    for (int e = 0; e < NBYTE; e++) begin
      if ((2'(e) & lane_m) == 2'b00) begin
        r   = elem_op(uop.opcode, 32'(uop.vs2 >> (8 * e)) & wmask,
                      32'(uop.vs1 >> (8 * e)) & wmask, wmask);
        sat = sat | r[32];
        for (int k = 0; k < 4; k++) begin
          if (2'(k) <= lane_m) begin
            data[8*(e+k) +: 8] = r[8*k +: 8];
          end
        end
      end
    end
  end

  assign result_valid     = uop_valid & (uop.opcode inside {valu_pkg::OP_ADD,
                            valu_pkg::OP_SUB, valu_pkg::OP_SADDU,
                            valu_pkg::OP_MINU, valu_pkg::OP_MAXU});
  assign result.rob_tag   = uop.rob_tag;
  assign result.w_data    = data;
  assign result.vsaturate = sat;

endmodule

`default_nettype wire

// File: rtl/valu_shift.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_defs.svh"

module valu_shift
(
  uop_valid,
  uop,
  result_valid,
  result
);
  input  logic                uop_valid;
  input  valu_pkg::alu_uop_t  uop;
  output logic                result_valid;
  output valu_pkg::pu2rob_t   result;

  localparam int NBYTE = `VALU_VLEN / 8;

  logic [`VALU_VLEN-1:0]  data;

  always_comb begin
    logic [1:0]  lane_m;
    logic [4:0]  amt_m;
    logic [4:0]  amt;
    logic [31:0] wmask;
    logic [31:0] a;
    logic [31:0] r;
    data = '0;
    case (uop.eew)
      valu_pkg::EEW8:  begin lane_m = 2'd0; amt_m = 5'd7;  end
      valu_pkg::EEW16: begin lane_m = 2'd1; amt_m = 5'd15; end
      default:         begin lane_m = 2'd3; amt_m = 5'd31; end
    endcase
    wmask = 32'hffff_ffff >> (8 * (3 - lane_m));
    for (int e = 0; e < NBYTE; e++) begin
      if ((2'(e) & lane_m) == 2'b00) begin
        a   = 32'(uop.vs2 >> (8 * e)) & wmask;
        amt = 5'(uop.vs1 >> (8 * e)) & amt_m;
        case (uop.opcode)
          valu_pkg::OP_SLL: r = a << amt;
          valu_pkg::OP_SRL: r = a >> amt;
          // sign-extend the element to 32 bits first
          valu_pkg::OP_SRA: r = $signed(a | ((a & ~(wmask >> 1)) != '0 ? ~wmask : '0)) >>> amt;
          default:          r = '0;
        endcase
        r = r & wmask;
        for (int k = 0; k < 4; k++) begin
          if (2'(k) <= lane_m) begin
            data[8*(e+k) +: 8] = r[8*k +: 8];
          end
        end
      end
    end
  end

  assign result_valid     = uop_valid & (uop.opcode inside {valu_pkg::OP_SLL,
                            valu_pkg::OP_SRL, valu_pkg::OP_SRA});
  assign result.rob_tag   = uop.rob_tag;
  assign result.w_data    = data;
  assign result.vsaturate = 1'b0;

endmodule

`default_nettype wire

// File: rtl/valu_mask.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_defs.svh"

module valu_mask
(
  uop_valid,
  uop,
  result_valid,
  result,
  two_cycle
);
  input  logic                  uop_valid;
  input  valu_pkg::alu_uop_t    uop;
  output logic                  result_valid;
  output valu_pkg::pipe_data_t  result;
  output logic                  two_cycle;

  localparam int HALF  = `VALU_HALF;
  localparam int CNT_W = $clog2(HALF) + 1;

  logic [`VALU_VLEN-1:0] data;
  logic [CNT_W-1:0]      cnt_lo;
  logic [CNT_W-1:0]      cnt_hi;

  always_comb begin
    case (uop.opcode)
      valu_pkg::OP_AND: data = uop.vs2 & uop.vs1;
      valu_pkg::OP_OR:  data = uop.vs2 | uop.vs1;
      valu_pkg::OP_XOR: data = uop.vs2 ^ uop.vs1;
      default:          data = '0;
    endcase
  end

  // first stage of cpop, one count per half
  always_comb begin
    cnt_lo = '0;
    cnt_hi = '0;
    for (int i = 0; i < HALF; i++) begin
      cnt_lo = cnt_lo + CNT_W'(uop.vs2[i]);
      cnt_hi = cnt_hi + CNT_W'(uop.vs2[HALF+i]);
    end
  end

  assign two_cycle    = uop_valid & (uop.opcode == valu_pkg::OP_CPOP);
  assign result_valid = uop_valid & (uop.opcode inside {valu_pkg::OP_AND,
                        valu_pkg::OP_OR, valu_pkg::OP_XOR, valu_pkg::OP_CPOP});

  assign result.rob_tag     = uop.rob_tag;
  assign result.opcode      = uop.opcode;
  assign result.result_data = data;
  assign result.cnt_lo      = cnt_lo;
  assign result.cnt_hi      = cnt_hi;
  assign result.vsaturate   = 1'b0;

endmodule

`default_nettype wire

// File: rtl/valu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_defs.svh"

module valu_unit
(
  clk,
  arst_n,
  uop_valid,
  uop,
  pop_rs,
  result_valid,
  result,
  result_ready,
  trap_flush
);
  input  logic                clk;
  input  logic                arst_n;
  input  logic                uop_valid;
  input  valu_pkg::alu_uop_t  uop;
  output logic                pop_rs;
  output logic                result_valid;
  output valu_pkg::pu2rob_t   result;
  input  logic                result_ready;
  input  logic                trap_flush;

  localparam int CNT_W = $clog2(`VALU_HALF) + 1;

  logic                  arith_valid;
  valu_pkg::pu2rob_t     arith_res;
  logic                  shift_valid;
  valu_pkg::pu2rob_t     shift_res;
  logic                  mask_valid;
  valu_pkg::pipe_data_t  mask_res;
  logic                  two_cycle;

  logic                  p0_valid;
  valu_pkg::pu2rob_t     p0_result;
  valu_pkg::pipe_data_t  p0_data;

  logic                  p1_valid;
  logic                  p1_valid_nxt;
  logic                  p1_load;
  valu_pkg::pipe_data_t  p1_data;
  valu_pkg::pu2rob_t     p1_result;
  logic [CNT_W:0]        cnt_sum;

  valu_arith u_arith (
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result_valid (arith_valid),
    .result       (arith_res)
  );

  valu_shift u_shift (
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result_valid (shift_valid),
    .result       (shift_res)
  );

  valu_mask u_mask (
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result_valid (mask_valid),
    .result       (mask_res),
    .two_cycle    (two_cycle)
  );

  assign p0_valid = arith_valid | shift_valid | mask_valid;

  always_comb begin
    if (arith_valid) begin
      p0_result = arith_res;
    end else if (shift_valid) begin
      p0_result = shift_res;
    end else begin
      p0_result.rob_tag   = mask_res.rob_tag;
      p0_result.w_data    = mask_res.result_data;
      p0_result.vsaturate = mask_res.vsaturate;
    end
  end

  // mask keeps its counts, other blocks go in as plain data
  always_comb begin
    if (mask_valid) begin
      p0_data = mask_res;
    end else begin
      p0_data.rob_tag     = p0_result.rob_tag;
      p0_data.opcode      = uop.opcode;
      p0_data.result_data = p0_result.w_data;
      p0_data.cnt_lo      = '0;
      p0_data.cnt_hi      = '0;
      p0_data.vsaturate   = p0_result.vsaturate;
    end
  end

  // second stage finish
  assign cnt_sum             = {1'b0, p1_data.cnt_lo} + {1'b0, p1_data.cnt_hi};
  assign p1_result.rob_tag   = p1_data.rob_tag;
  assign p1_result.w_data    = (p1_data.opcode == valu_pkg::OP_CPOP) ?
                               `VALU_VLEN'(cnt_sum) : p1_data.result_data;
  assign p1_result.vsaturate = p1_data.vsaturate;

  always_comb begin
    result_valid = 1'b0;
    result       = p0_result;
    pop_rs       = 1'b0;
    p1_load      = 1'b0;
    p1_valid_nxt = p1_valid;
    if (p1_valid) begin
      result_valid = 1'b1;
      result       = p1_result;
      if (result_ready) begin
        // keep order behind p1 by routing the head through it
        p1_load      = p0_valid;
        pop_rs       = p0_valid;
        p1_valid_nxt = p0_valid;
      end
    end else if (p0_valid) begin
      if (two_cycle) begin
        p1_load      = 1'b1;
        pop_rs       = 1'b1;
        p1_valid_nxt = 1'b1;
      end else begin
        result_valid = 1'b1;
        pop_rs       = result_ready;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      p1_valid <= 1'b0;
    end else if (trap_flush) begin
      p1_valid <= 1'b0;
    end else begin
      p1_valid <= p1_valid_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (p1_load) begin
      p1_data <= p0_data;
    end
  end

endmodule

`default_nettype wire

// File: rtl/valu_top.sv
`timescale 1ns/1ps
`default_nettype none

module valu_top
(
  clk,
  arst_n,
  push,
  push_uop,
  rs_full,
  result_valid,
  result,
  result_ready,
  trap_flush
);
  input  logic                clk;
  input  logic                arst_n;
  input  logic                push;
  input  valu_pkg::alu_uop_t  push_uop;
  output logic                rs_full;
  output logic                result_valid;
  output valu_pkg::pu2rob_t   result;
  input  logic                result_ready;
  input  logic                trap_flush;

  logic                uop_valid;
  valu_pkg::alu_uop_t  uop;
  logic                pop_rs;

  valu_rs u_rs (
    .clk          (clk),
    .arst_n       (arst_n),
    .push         (push),
    .push_uop     (push_uop),
    .full         (rs_full),
    .trap_flush   (trap_flush),
    .pop_rs       (pop_rs),
    .uop_valid    (uop_valid),
    .uop          (uop)
  );

  valu_unit u_unit (
    .clk          (clk),
    .arst_n       (arst_n),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .pop_rs       (pop_rs),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready),
    .trap_flush   (trap_flush)
  );

endmodule

`default_nettype wire

// File: sim/valu_props.sv
`timescale 1ns/1ps
`default_nettype none

module valu_props (
  input logic               clk,
  input logic               arst_n,
  input logic               uop_valid,
  input logic               pop_rs,
  input logic               result_valid,
  input valu_pkg::pu2rob_t  result,
  input logic               result_ready,
  input logic               trap_flush
);

  a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !result_valid && !pop_rs)
    else $error("result_valid or pop_rs high during reset");

  // stalled result holds until taken
  a_hold: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid && !result_ready && !trap_flush |=> result_valid && $stable(result))
    else $error("result changed under back-pressure");

  // a pop needs a head entry and never happens while a result is stalled
  a_pop_valid: assert property (@(posedge clk) disable iff (!arst_n)
    pop_rs |-> uop_valid && (result_ready || !result_valid))
    else $error("pop_rs with an empty station or a stalled result");

  a_flush_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    trap_flush |=> !result_valid || uop_valid)
    else $error("stale result after trap_flush");

endmodule

bind valu_unit valu_props i_props (
  .clk          (clk),
  .arst_n       (arst_n),
  .uop_valid    (uop_valid),
  .pop_rs       (pop_rs),
  .result_valid (result_valid),
  .result       (result),
  .result_ready (result_ready),
  .trap_flush   (trap_flush)
);

`default_nettype wire

// File: sim/valu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_defs.svh"

module valu_tb;

  logic                    clk;
  logic                    arst_n;
  logic                    push;
  valu_pkg::alu_uop_t      push_uop;
  logic                    rs_full;
  logic                    result_valid;
  valu_pkg::pu2rob_t       result;
  logic                    result_ready;
  logic                    trap_flush;

  valu_pkg::pu2rob_t       exp_q[$];
  string                   test_name;
  logic                    rand_ready;
  logic [`VALU_TAG_W-1:0]  next_tag;

  valu_top i_valu_top (
    .clk          (clk),
    .arst_n       (arst_n),
    .push         (push),
    .push_uop     (push_uop),
    .rs_full      (rs_full),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready),
    .trap_flush   (trap_flush)
  );

  always #2 clk = ~clk;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  // expected result, element by element
  function automatic valu_pkg::pu2rob_t valu_model(input valu_pkg::alu_uop_t u);
    valu_pkg::pu2rob_t r;
    int                ew;
    logic [63:0]       a;
    logic [63:0]       b;
    logic [63:0]       m;
    logic [63:0]       y;
    logic [5:0]        sh;
    r.rob_tag   = u.rob_tag;
    r.w_data    = '0;
    r.vsaturate = 1'b0;
    case (u.eew)
      valu_pkg::EEW8:  ew = 8;
      valu_pkg::EEW16: ew = 16;
      default:         ew = 32;
    endcase
    m = (64'd1 << ew) - 64'd1;
    case (u.opcode)
      valu_pkg::OP_AND:  r.w_data = u.vs1 & u.vs2;
      valu_pkg::OP_OR:   r.w_data = u.vs1 | u.vs2;
      valu_pkg::OP_XOR:  r.w_data = u.vs1 ^ u.vs2;
      valu_pkg::OP_CPOP: r.w_data = `VALU_VLEN'($countones(u.vs2));
      default: begin
        for (int i = 0; i < `VALU_VLEN / ew; i++) begin
          a  = 64'(u.vs2 >> (i * ew)) & m;
          b  = 64'(u.vs1 >> (i * ew)) & m;
          sh = 6'(b & 64'(ew - 1));
          case (u.opcode)
            valu_pkg::OP_ADD:  y = a + b;
            valu_pkg::OP_SUB:  y = a - b;
            valu_pkg::OP_SADDU: begin
              y = a + b;
              if (y > m) begin
                y           = m;
                r.vsaturate = 1'b1;
              end
            end
            valu_pkg::OP_MINU: y = (a < b) ? a : b;
            valu_pkg::OP_MAXU: y = (a < b) ? b : a;
            valu_pkg::OP_SLL:  y = a << sh;
            valu_pkg::OP_SRL:  y = a >> sh;
            // move the element to the top so the sign bit leads
            default:           y = 64'($signed(a << (64 - ew)) >>> (64 - ew + sh));
          endcase
          r.w_data = r.w_data | (`VALU_VLEN'(y & m) << (i * ew));
        end
      end
    endcase
    return r;
  endfunction

  task automatic check_result(input valu_pkg::pu2rob_t exp, input valu_pkg::pu2rob_t act);
    if (act.rob_tag !== exp.rob_tag) begin
      stop_run($sformatf("MISMATCH %s rob_tag expected %0h actual %0h",
                         test_name, exp.rob_tag, act.rob_tag));
    end
    if (act.w_data !== exp.w_data) begin
      stop_run($sformatf("MISMATCH %s w_data expected %h actual %h",
                         test_name, exp.w_data, act.w_data));
    end
    if (act.vsaturate !== exp.vsaturate) begin
      stop_run($sformatf("MISMATCH %s vsaturate expected %b actual %b",
                         test_name, exp.vsaturate, act.vsaturate));
    end
  endtask

  task automatic check_level(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("MISMATCH %s %s expected %b actual %b",
                         test_name, what, exp, act));
    end
  endtask

  // scoreboard, sampled half a cycle ahead of the transfer edge
  always @(negedge clk) begin
    if (arst_n && result_valid && result_ready) begin
      if (exp_q.size() == 0) begin
        stop_run({"result arrived with nothing pending in test ", test_name});
      end else begin
        check_result(exp_q.pop_front(), result);
      end
    end
  end

  function automatic logic [`VALU_VLEN-1:0] rand_vec();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic step();
    @(posedge clk);
    #0.5;
    if (rand_ready) begin
      result_ready = 1'($urandom_range(0, 1));
    end
  endtask

  task automatic push_op(input valu_pkg::alu_op_e op, input valu_pkg::eew_e w,
                         input logic [`VALU_VLEN-1:0] vs1,
                         input logic [`VALU_VLEN-1:0] vs2);
    valu_pkg::alu_uop_t u;
    int                 t;
    u.rob_tag = next_tag;
    u.opcode  = op;
    u.eew     = w;
    u.vs1     = vs1;
    u.vs2     = vs2;
    t         = 0;
    while (rs_full) begin
      step();
      t++;
      if (t > 100) begin
        stop_run({"reservation station stayed full in test ", test_name});
      end
    end
    push     = 1'b1;
    push_uop = u;
    exp_q.push_back(valu_model(u));
    next_tag = next_tag + 1'b1;
    step();
    push = 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0) begin
      step();
      t++;
      if (t > 500) begin
        stop_run({"results did not come out in test ", test_name});
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    push         = 1'b0;
    push_uop     = '0;
    result_ready = 1'b0;
    trap_flush   = 1'b0;
    rand_ready   = 1'b0;
    next_tag     = '0;
    test_name    = "reset";
    void'($urandom(83));
    repeat (4) @(posedge clk);
    #0.5;
    arst_n = 1'b1;
    step();

    test_name    = "arith";
    result_ready = 1'b1;
    for (int w = 0; w < 3; w++) begin
      for (int n = 0; n < 20; n++) begin
        push_op(valu_pkg::alu_op_e'(4'($urandom_range(0, 4))), valu_pkg::eew_e'(2'(w)),
                rand_vec(), rand_vec());
      end
      push_op(valu_pkg::OP_SADDU, valu_pkg::eew_e'(2'(w)), '1, '1);
      push_op(valu_pkg::OP_SADDU, valu_pkg::eew_e'(2'(w)), `VALU_VLEN'(1), '1);
    end
    wait_drain();

    test_name = "shift";
    for (int w = 0; w < 3; w++) begin
      for (int n = 0; n < 20; n++) begin
        push_op(valu_pkg::alu_op_e'(4'($urandom_range(5, 7))), valu_pkg::eew_e'(2'(w)),
                rand_vec(), rand_vec());
      end
      // largest shift amount in every element
      for (int s = 5; s < 8; s++) begin
        push_op(valu_pkg::alu_op_e'(4'(s)), valu_pkg::eew_e'(2'(w)), '1, rand_vec());
      end
    end
    wait_drain();

    test_name = "mask";
    for (int n = 0; n < 20; n++) begin
      push_op(valu_pkg::alu_op_e'(4'($urandom_range(8, 10))),
              valu_pkg::eew_e'(2'($urandom_range(0, 2))), rand_vec(), rand_vec());
    end
    push_op(valu_pkg::OP_CPOP, valu_pkg::EEW8, rand_vec(), '0);
    push_op(valu_pkg::OP_CPOP, valu_pkg::EEW8, rand_vec(), '1);
    for (int n = 0; n < 6; n++) begin
      push_op(valu_pkg::OP_CPOP, valu_pkg::EEW32, rand_vec(), rand_vec());
    end
    wait_drain();

    test_name  = "backpressure";
    rand_ready = 1'b1;
    push_op(valu_pkg::OP_CPOP, valu_pkg::EEW8, rand_vec(), rand_vec());
    push_op(valu_pkg::OP_ADD, valu_pkg::EEW16, rand_vec(), rand_vec());
    push_op(valu_pkg::OP_CPOP, valu_pkg::EEW8, rand_vec(), rand_vec());
    push_op(valu_pkg::OP_SRA, valu_pkg::EEW8, rand_vec(), rand_vec());
    for (int n = 0; n < 60; n++) begin
      push_op(valu_pkg::alu_op_e'(4'($urandom_range(0, 11))),
              valu_pkg::eew_e'(2'($urandom_range(0, 2))), rand_vec(), rand_vec());
    end
    wait_drain();
    rand_ready   = 1'b0;
    result_ready = 1'b0;

    test_name = "flush";
    // cpop moves into the second stage, the rest fill the station
    push_op(valu_pkg::OP_CPOP, valu_pkg::EEW8, rand_vec(), rand_vec());
    for (int n = 0; n < `VALU_RS_DEPTH; n++) begin
      push_op(valu_pkg::alu_op_e'(4'($urandom_range(0, 11))),
              valu_pkg::eew_e'(2'($urandom_range(0, 2))), rand_vec(), rand_vec());
    end
    check_level("rs_full", 1'b1, rs_full);
    trap_flush = 1'b1;
    step();
    trap_flush   = 1'b0;
    result_ready = 1'b1;
    exp_q.delete();
    for (int n = 0; n < 4; n++) begin
      check_level("result_valid", 1'b0, result_valid);
      check_level("rs_full", 1'b0, rs_full);
      step();
    end
    for (int n = 0; n < 8; n++) begin
      push_op(valu_pkg::alu_op_e'(4'($urandom_range(0, 11))),
              valu_pkg::eew_e'(2'($urandom_range(0, 2))), rand_vec(), rand_vec());
    end
    wait_drain();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/valu_pkg.sv
rtl/valu_rs.sv
rtl/valu_arith.sv
rtl/valu_shift.sv
rtl/valu_mask.sv
rtl/valu_unit.sv
rtl/valu_top.sv
sim/valu_props.sv
sim/valu_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module valu_tb -o valu_sim &&
./obj_dir/valu_sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
